// File: noc_pkg.sv
package noc_pkg;

	// mesh size
	localparam int NX = 2;
	localparam int NY = 2;
	localparam int NC = NX * NY;

	// router geometry
	localparam int P = 5;
	localparam int B = 4; // flits per input buffer

	// port numbering, same as the mesh wiring
	localparam int PORT_LOCAL = 0;
	localparam int PORT_EAST = 1;
	localparam int PORT_NORTH = 2;
	localparam int PORT_WEST = 3;
	localparam int PORT_SOUTH = 4;

	typedef logic [0:0] x_t;
	typedef logic [0:0] y_t;
	typedef logic [1:0] node_t; // y * NX + x
	typedef logic [P-1:0] port_sel_t; // one-hot port set
	typedef logic [2:0] cnt_t; // 0 .. B

	typedef enum logic {
		ARB_IDLE,
		ARB_LOCKED
	} arb_state_t;

endpackage

// File: flit_pkg.sv
package flit_pkg;

	localparam int PAYLOAD_W = 32;

	typedef logic [PAYLOAD_W-1:0] payload_t;

	// dst fields are repeated in every flit of a packet
	typedef struct packed {
		logic head;
		logic tail; // single-flit packet has head and tail set
		noc_pkg::x_t dst_x;
		noc_pkg::y_t dst_y;
		noc_pkg::node_t src;
		payload_t payload;
	} flit_t;

endpackage

// File: input_port.sv
`timescale 1ns/1ns

module input_port #(
	parameter noc_pkg::x_t X = 1'b0,
	parameter noc_pkg::y_t Y = 1'b0
) (
	input logic clk,
	input logic arst_n,
	input flit_pkg::flit_t flit,
	input logic flit_wr,
	output flit_pkg::flit_t head_flit,
	output noc_pkg::port_sel_t req,
	input logic pop,
	output logic credit
);

	flit_pkg::flit_t mem [noc_pkg::B];
	logic [$clog2(noc_pkg::B)-1:0] wr_ptr;
	logic [$clog2(noc_pkg::B)-1:0] rd_ptr;
	noc_pkg::cnt_t count;

	always_ff @(posedge clk) begin
		if (flit_wr)
			mem[wr_ptr] <= flit;
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
			credit <= 1'b0;
		end else begin
			if (flit_wr)
				wr_ptr <= wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= rd_ptr + 1'b1;
			count <= count + noc_pkg::cnt_t'(flit_wr) - noc_pkg::cnt_t'(pop);
			credit <= pop; // one slot freed upstream
		end
	end

	assign head_flit = mem[rd_ptr];

	// XY routing, x first
	always_comb begin
		req = '0;
		if (count != '0) begin
			if (head_flit.dst_x > X)
				req[noc_pkg::PORT_EAST] = 1'b1;
			else if (head_flit.dst_x < X)
				req[noc_pkg::PORT_WEST] = 1'b1;
			else if (head_flit.dst_y > Y)
				req[noc_pkg::PORT_SOUTH] = 1'b1; // y grows southward
			else if (head_flit.dst_y < Y)
				req[noc_pkg::PORT_NORTH] = 1'b1;
			else
				req[noc_pkg::PORT_LOCAL] = 1'b1;
		end
	end

	// upstream credit counter must stop writes into a full buffer
	a_no_overflow: assert property (@(posedge clk) disable iff (!arst_n)
		flit_wr |-> count != noc_pkg::cnt_t'(noc_pkg::B))
		else $error("input_port: write into full buffer");

	// router grants only inputs that hold a flit
	a_no_underflow: assert property (@(posedge clk) disable iff (!arst_n)
		pop |-> count != '0)
		else $error("input_port: pop from empty buffer");

endmodule

// File: port_arbiter.sv
`timescale 1ns/1ns

module port_arbiter (
	input logic clk,
	input logic arst_n,
	input noc_pkg::port_sel_t req,
	input logic credit_ok,
	input logic tail,
	output noc_pkg::port_sel_t grant
);

	noc_pkg::arb_state_t state;
	noc_pkg::port_sel_t last; // last winner and owner while locked
	noc_pkg::port_sel_t hi_req;
	noc_pkg::port_sel_t pick;

	// round robin from just above the last winner
	always_comb begin
		hi_req = req & ~(last | (last - 1'b1));
		if (hi_req != '0)
			pick = hi_req & (~hi_req + 1'b1);
		else
			pick = req & (~req + 1'b1);
	end

	always_comb begin
		grant = '0;
		if (credit_ok) begin
			if (state == noc_pkg::ARB_LOCKED)
				grant = req & last; // worm owner only
			else
				grant = pick;
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state <= noc_pkg::ARB_IDLE;
			last <= '0;
		end else if (grant != '0) begin
			last <= grant;
			if (tail)
				state <= noc_pkg::ARB_IDLE;
			else
				state <= noc_pkg::ARB_LOCKED;
		end
	end

	a_grant_onehot: assert property (@(posedge clk) disable iff (!arst_n)
		$onehot0(grant))
		else $error("port_arbiter: more than one grant");

endmodule

// File: credit_counter.sv
`timescale 1ns/1ns

module credit_counter (
	input logic clk,
	input logic arst_n,
	input logic sent,
	input logic credit,
	output logic count_ok
);

	noc_pkg::cnt_t count; // free slots downstream

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n)
			count <= noc_pkg::cnt_t'(noc_pkg::B);
		else if (sent && !credit)
			count <= count - 1'b1;
		else if (credit && !sent)
			count <= count + 1'b1;
	end

	assign count_ok = count != '0;

	a_no_negative: assert property (@(posedge clk) disable iff (!arst_n)
		(sent && !credit) |-> count != '0)
		else $error("credit_counter: flit sent without credit");

	// downstream returns no more credits than it has slots
	a_no_excess: assert property (@(posedge clk) disable iff (!arst_n)
		(credit && !sent) |-> count != noc_pkg::cnt_t'(noc_pkg::B))
		else $error("credit_counter: credit above buffer depth");

endmodule

// File: router.sv
`timescale 1ns/1ns

module router #(
	parameter noc_pkg::x_t X = 1'b0,
	parameter noc_pkg::y_t Y = 1'b0
) (
	input logic clk,
	input logic arst_n,
	input flit_pkg::flit_t flit_in [noc_pkg::P],
	input noc_pkg::port_sel_t flit_in_wr,
	output noc_pkg::port_sel_t credit_out,
	output flit_pkg::flit_t flit_out [noc_pkg::P],
	output noc_pkg::port_sel_t flit_out_wr,
	input noc_pkg::port_sel_t credit_in
);

	flit_pkg::flit_t head [noc_pkg::P];
	noc_pkg::port_sel_t req_in [noc_pkg::P]; // per input, output wanted
	noc_pkg::port_sel_t req_out [noc_pkg::P]; // per output, inputs asking
	noc_pkg::port_sel_t grant [noc_pkg::P]; // per output
	flit_pkg::flit_t sel_flit [noc_pkg::P];
	noc_pkg::port_sel_t count_ok;
	noc_pkg::port_sel_t sent;
	noc_pkg::port_sel_t pop;

	for (genvar i = 0; i < noc_pkg::P; i++) begin : g_in
		input_port #(
			.X(X),
			.Y(Y)
		) u_input_port (
			.clk(clk),
			.arst_n(arst_n),
			.flit(flit_in[i]),
			.flit_wr(flit_in_wr[i]),
			.head_flit(head[i]),
			.req(req_in[i]),
			.pop(pop[i]),
			.credit(credit_out[i])
		);
	end

	always_comb begin
		for (int o = 0; o < noc_pkg::P; o++) begin
			for (int i = 0; i < noc_pkg::P; i++)
				req_out[o][i] = req_in[i][o];
		end
	end

	for (genvar o = 0; o < noc_pkg::P; o++) begin : g_out
		port_arbiter u_port_arbiter (
			.clk(clk),
			.arst_n(arst_n),
			.req(req_out[o]),
			.credit_ok(count_ok[o]),
			.tail(sel_flit[o].tail),
			.grant(grant[o])
		);

		credit_counter u_credit_counter (
			.clk(clk),
			.arst_n(arst_n),
			.sent(sent[o]),
			.credit(credit_in[o]),
			.count_ok(count_ok[o])
		);
	end

	// crossbar select and pop
	always_comb begin
		pop = '0;
		for (int o = 0; o < noc_pkg::P; o++) begin
			sel_flit[o] = '0;
			sent[o] = |grant[o];
			for (int i = 0; i < noc_pkg::P; i++) begin
				if (grant[o][i]) begin
					sel_flit[o] = head[i];
					pop[i] = 1'b1;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		for (int o = 0; o < noc_pkg::P; o++) begin
			if (sent[o])
				flit_out[o] <= sel_flit[o];
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n)
			flit_out_wr <= '0;
		else
			flit_out_wr <= sent;
	end

endmodule

// File: noc.sv
`timescale 1ns/1ns

module noc (
	input logic clk,
	input logic arst_n,
	input flit_pkg::flit_t flit_in [noc_pkg::NC],
	input logic [noc_pkg::NC-1:0] flit_in_wr,
	output logic [noc_pkg::NC-1:0] credit_out,
	output flit_pkg::flit_t flit_out [noc_pkg::NC],
	output logic [noc_pkg::NC-1:0] flit_out_wr,
	input logic [noc_pkg::NC-1:0] credit_in
);

	flit_pkg::flit_t rt_flit_in [noc_pkg::NC][noc_pkg::P];
	noc_pkg::port_sel_t rt_flit_in_wr [noc_pkg::NC];
	noc_pkg::port_sel_t rt_credit_out [noc_pkg::NC];
	flit_pkg::flit_t rt_flit_out [noc_pkg::NC][noc_pkg::P];
	noc_pkg::port_sel_t rt_flit_out_wr [noc_pkg::NC];
	noc_pkg::port_sel_t rt_credit_in [noc_pkg::NC];

	for (genvar x = 0; x < noc_pkg::NX; x++) begin : g_x
		for (genvar y = 0; y < noc_pkg::NY; y++) begin : g_y
			localparam int ID = y * noc_pkg::NX + x;

			router #(
				.X(noc_pkg::x_t'(x)),
				.Y(noc_pkg::y_t'(y))
			) u_router (
				.clk(clk),
				.arst_n(arst_n),
				.flit_in(rt_flit_in[ID]),
				.flit_in_wr(rt_flit_in_wr[ID]),
				.credit_out(rt_credit_out[ID]),
				.flit_out(rt_flit_out[ID]),
				.flit_out_wr(rt_flit_out_wr[ID]),
				.credit_in(rt_credit_in[ID])
			);

			if (x < noc_pkg::NX - 1) begin : g_east // from west port of x+1
				assign rt_flit_in[ID][noc_pkg::PORT_EAST] = rt_flit_out[ID+1][noc_pkg::PORT_WEST];
				assign rt_flit_in_wr[ID][noc_pkg::PORT_EAST] = rt_flit_out_wr[ID+1][noc_pkg::PORT_WEST];
				assign rt_credit_in[ID][noc_pkg::PORT_EAST] = rt_credit_out[ID+1][noc_pkg::PORT_WEST];
			end else begin : g_east_edge
				assign rt_flit_in[ID][noc_pkg::PORT_EAST] = '0;
				assign rt_flit_in_wr[ID][noc_pkg::PORT_EAST] = 1'b0;
				assign rt_credit_in[ID][noc_pkg::PORT_EAST] = 1'b0;
			end

			if (y > 0) begin : g_north // from south port of y-1
				localparam int NB = ID - noc_pkg::NX;
				assign rt_flit_in[ID][noc_pkg::PORT_NORTH] = rt_flit_out[NB][noc_pkg::PORT_SOUTH];
				assign rt_flit_in_wr[ID][noc_pkg::PORT_NORTH] = rt_flit_out_wr[NB][noc_pkg::PORT_SOUTH];
				assign rt_credit_in[ID][noc_pkg::PORT_NORTH] = rt_credit_out[NB][noc_pkg::PORT_SOUTH];
			end else begin : g_north_edge
				assign rt_flit_in[ID][noc_pkg::PORT_NORTH] = '0;
				assign rt_flit_in_wr[ID][noc_pkg::PORT_NORTH] = 1'b0;
				assign rt_credit_in[ID][noc_pkg::PORT_NORTH] = 1'b0;
			end

			if (x > 0) begin : g_west // from east port of x-1
				assign rt_flit_in[ID][noc_pkg::PORT_WEST] = rt_flit_out[ID-1][noc_pkg::PORT_EAST];
				assign rt_flit_in_wr[ID][noc_pkg::PORT_WEST] = rt_flit_out_wr[ID-1][noc_pkg::PORT_EAST];
				assign rt_credit_in[ID][noc_pkg::PORT_WEST] = rt_credit_out[ID-1][noc_pkg::PORT_EAST];
			end else begin : g_west_edge
				assign rt_flit_in[ID][noc_pkg::PORT_WEST] = '0;
				assign rt_flit_in_wr[ID][noc_pkg::PORT_WEST] = 1'b0;
				assign rt_credit_in[ID][noc_pkg::PORT_WEST] = 1'b0;
			end

			if (y < noc_pkg::NY - 1) begin : g_south // from north port of y+1
				localparam int SB = ID + noc_pkg::NX;
				assign rt_flit_in[ID][noc_pkg::PORT_SOUTH] = rt_flit_out[SB][noc_pkg::PORT_NORTH];
				assign rt_flit_in_wr[ID][noc_pkg::PORT_SOUTH] = rt_flit_out_wr[SB][noc_pkg::PORT_NORTH];
				assign rt_credit_in[ID][noc_pkg::PORT_SOUTH] = rt_credit_out[SB][noc_pkg::PORT_NORTH];
			end else begin : g_south_edge
				assign rt_flit_in[ID][noc_pkg::PORT_SOUTH] = '0;
				assign rt_flit_in_wr[ID][noc_pkg::PORT_SOUTH] = 1'b0;
				assign rt_credit_in[ID][noc_pkg::PORT_SOUTH] = 1'b0;
			end

			// local port straight to the core
			assign rt_flit_in[ID][noc_pkg::PORT_LOCAL] = flit_in[ID];
			assign rt_flit_in_wr[ID][noc_pkg::PORT_LOCAL] = flit_in_wr[ID];
			assign credit_out[ID] = rt_credit_out[ID][noc_pkg::PORT_LOCAL];
			assign flit_out[ID] = rt_flit_out[ID][noc_pkg::PORT_LOCAL];
			assign flit_out_wr[ID] = rt_flit_out_wr[ID][noc_pkg::PORT_LOCAL];
			assign rt_credit_in[ID][noc_pkg::PORT_LOCAL] = credit_in[ID];
		end
	end

endmodule

// File: tb_noc.sv
`timescale 1ns/1ns

module tb_noc;

	logic clk = 1'b0;
	logic arst_n = 1'b0;
	flit_pkg::flit_t flit_in [noc_pkg::NC] = '{default: '0};
	logic [noc_pkg::NC-1:0] flit_in_wr = '0;
	logic [noc_pkg::NC-1:0] credit_out;
	flit_pkg::flit_t flit_out [noc_pkg::NC];
	logic [noc_pkg::NC-1:0] flit_out_wr;
	logic [noc_pkg::NC-1:0] credit_in = '0;

	flit_pkg::flit_t tx_q [noc_pkg::NC][$]; // flits waiting at each source
	flit_pkg::flit_t exp_q [noc_pkg::NC * noc_pkg::NC][$]; // per src/dst pair
	int cred [noc_pkg::NC] = '{default: noc_pkg::B}; // source credits toward the router
	int owed [noc_pkg::NC] = '{default: 0}; // sink credits not yet returned
	logic [noc_pkg::NC-1:0] stall = '0;
	logic [noc_pkg::NC-1:0] in_pkt = '0;
	noc_pkg::node_t pkt_src [noc_pkg::NC] = '{default: '0};
	int held_rx = 0; // arrivals while a sink stalls
	logic quiet = 1'b1;
	logic [31:0] rng = 32'h42d1_1bfa;
	int errors = 0;
	int timeouts = 0;

	always #10 clk = ~clk;

	noc u_noc (
		.clk(clk),
		.arst_n(arst_n),
		.flit_in(flit_in),
		.flit_in_wr(flit_in_wr),
		.credit_out(credit_out),
		.flit_out(flit_out),
		.flit_out_wr(flit_out_wr),
		.credit_in(credit_in)
	);

	function automatic logic [31:0] next_rand();
		rng = rng * 32'd1664525 + 32'd1013904223;
		return rng;
	endfunction

	task automatic report_mismatch(input string test, input logic [63:0] expected,
			input logic [63:0] actual);
		errors++;
		$display("CHECK FAILED %s: expected %0h, actual %0h", test, expected, actual);
	endtask

	task automatic send_packet(input int src, input int dst, input int len);
		flit_pkg::flit_t f;
		for (int i = 0; i < len; i++) begin
			f.head = (i == 0);
			f.tail = (i == len - 1);
			f.dst_x = noc_pkg::x_t'(dst % noc_pkg::NX);
			f.dst_y = noc_pkg::y_t'(dst / noc_pkg::NX);
			f.src = noc_pkg::node_t'(src);
			f.payload = next_rand();
			tx_q[src].push_back(f);
			exp_q[src * noc_pkg::NC + dst].push_back(f);
		end
	endtask

	task automatic check_rx(input int n, input flit_pkg::flit_t f);
		int pair;
		flit_pkg::flit_t exp;
		pair = int'(f.src) * noc_pkg::NC + n;
		assert (int'(f.dst_y) * noc_pkg::NX + int'(f.dst_x) == n)
			else report_mismatch("delivery node", 64'(n), 64'({f.dst_y, f.dst_x}));
		if (in_pkt[n]) begin
			assert (!f.head && f.src == pkt_src[n])
				else report_mismatch("worm integrity", 64'(pkt_src[n]), 64'(f.src));
		end else begin
			assert (f.head) else begin
				errors++;
				$display("body flit reached node %0d without a head flit", n);
			end
		end
		if (f.head)
			pkt_src[n] = f.src;
		in_pkt[n] = !f.tail;
		if (exp_q[pair].size() == 0) begin
			errors++;
			$display("node %0d received a flit from node %0d that was never sent", n, f.src);
		end else begin
			exp = exp_q[pair].pop_front();
			assert (f == exp) else report_mismatch("ordering", 64'(exp), 64'(f));
		end
	endtask

	// sources count returned credits and send while credit is left
	always @(negedge clk) begin
		for (int n = 0; n < noc_pkg::NC; n++) begin
			flit_in_wr[n] = 1'b0;
			if (arst_n) begin
				if (credit_out[n]) begin
					cred[n]++;
					assert (cred[n] <= noc_pkg::B)
						else report_mismatch("credit conservation", 64'(noc_pkg::B),
							64'(cred[n]));
				end
				if (tx_q[n].size() > 0 && cred[n] > 0) begin
					flit_in[n] = tx_q[n].pop_front();
					flit_in_wr[n] = 1'b1;
					cred[n]--;
				end
			end
		end
	end

	// sinks return one credit a cycle after each flit unless stalled
	always @(negedge clk) begin
		for (int n = 0; n < noc_pkg::NC; n++) begin
			credit_in[n] = 1'b0;
			if (arst_n) begin
				if (owed[n] > 0 && !stall[n]) begin
					credit_in[n] = 1'b1;
					owed[n]--;
				end
				if (flit_out_wr[n]) begin
					check_rx(n, flit_out[n]);
					owed[n]++;
					if (stall[n])
						held_rx++;
				end
			end
		end
	end

	a_reset_quiet: assert property (@(posedge clk)
		quiet |-> (flit_out_wr == '0 && credit_out == '0))
		else report_mismatch("reset", 64'h0, {56'h0, flit_out_wr, credit_out});

	a_hold_limit: assert property (@(posedge clk) held_rx <= noc_pkg::B)
		else report_mismatch("back-pressure", 64'(noc_pkg::B), 64'(held_rx));

	task automatic wait_drained(input string what, input int limit);
		bit busy;
		busy = 1'b1;
		for (int c = 0; c < limit && busy; c++) begin
			@(posedge clk);
			busy = 1'b0;
			for (int n = 0; n < noc_pkg::NC; n++)
				if (tx_q[n].size() != 0 || owed[n] != 0 || cred[n] != noc_pkg::B)
					busy = 1'b1;
			for (int p = 0; p < noc_pkg::NC * noc_pkg::NC; p++)
				if (exp_q[p].size() != 0)
					busy = 1'b1;
		end
		if (busy) begin
			timeouts++;
			$display("timeout: %s traffic did not drain within %0d cycles", what, limit);
		end
	endtask

	initial begin
		int c;
		int dst;
		int len;
		repeat (3) @(negedge clk);
		arst_n = 1'b1;
		repeat (2) @(posedge clk);
		quiet = 1'b0;
		for (int s = 0; s < noc_pkg::NC; s++) begin
			for (int d = 0; d < noc_pkg::NC; d++)
				send_packet(s, d, 1);
		end
		wait_drained("single-flit", 500);
		// all sources at once
		for (int k = 0; k < 20; k++) begin
			for (int s = 0; s < noc_pkg::NC; s++) begin
				dst = int'(next_rand() >> 16) % noc_pkg::NC;
				len = 1 + int'(next_rand() >> 16) % 3;
				send_packet(s, dst, len);
			end
		end
		wait_drained("random", 5000);
		held_rx = 0;
		stall[3] = 1'b1;
		for (int s = 0; s < 3; s++) begin
			for (int k = 0; k < 3; k++)
				send_packet(s, 3, 2);
		end
		for (c = 0; c < 1000 && held_rx < noc_pkg::B; c++)
			@(posedge clk);
		if (held_rx < noc_pkg::B) begin
			timeouts++;
			$display("timeout: stalled node 3 never filled its router credits");
		end
		repeat (40) @(posedge clk); // nothing more may arrive
		stall[3] = 1'b0;
		wait_drained("back-pressure", 2000);
		$display("errors: %0d check, %0d timeout", errors, timeouts);
		if (errors == 0 && timeouts == 0) begin
			$display("Simulation completed successfully");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

// File: vlog.f
noc_pkg.sv
flit_pkg.sv
input_port.sv
port_arbiter.sv
credit_counter.sv
router.sv
noc.sv
tb_noc.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS ?= --binary --timing --assert -Wno-fatal
TOP ?= tb_noc
FILELIST ?= vlog.f
LOG ?= sim.log
PASS_MSG = Simulation completed successfully

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run, and check the log"
	@echo "  clean  remove build output and log"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -o V$(TOP)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
